// ==== hdl/branch_pkg.sv ====
// ----------------------------------------------------------
// Branch package
// Shared address type, branch condition encoding, entry and
// flag structs, and the entry index sizing for the multiway
// branch unit
// ----------------------------------------------------------

package branch_pkg;

    // Width of an instruction address
    localparam int PC_WIDTH = 10;

    // Instruction address
    typedef logic [PC_WIDTH-1:0] pc_t;

    // Conditions a branch entry can test against the ALU flags
    // Positive means neither zero nor negative
    typedef enum logic [2:0] {
        COND_NEVER    = 3'd0,
        COND_ALWAYS   = 3'd1,
        COND_ZERO     = 3'd2,
        COND_NONZERO  = 3'd3,
        COND_NEGATIVE = 3'd4,
        COND_POSITIVE = 3'd5
    } branch_cond_t;

    // One branch entry as written by software
    typedef struct packed {
        pc_t          origin;
        pc_t          destination;
        branch_cond_t condition;
        logic         predict_taken;
        logic         enable;
    } branch_cfg_t;

    // Flags of the previous ALU result
    typedef struct packed {
        logic zero;
        logic negative;
    } alu_flags_t;

    // Index width for a given number of entries, never below one bit
    function automatic int BRANCH_INDEX_WIDTH(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

endpackage

// ==== hdl/branch_config_regs.sv ====
// ----------------------------------------------------------
// Branch configuration registers
// Holds the branch entries; software replaces one whole
// entry per cycle through a simple write strobe
// ----------------------------------------------------------

module branch_config_regs #(
    parameter int BRANCH_COUNT = 4
) (
    input  logic                    clock,
    input  logic                    rst,

    // Entry write port, one entry per strobe
    input  logic                    config_write,
    input  logic [branch_pkg::BRANCH_INDEX_WIDTH(BRANCH_COUNT)-1:0] config_index,
    input  branch_pkg::branch_cfg_t config_data,

    // All entries, straight to the detectors
    output branch_pkg::branch_cfg_t entries [BRANCH_COUNT]
);

    import branch_pkg::*;

    localparam int INDEX_WIDTH = BRANCH_INDEX_WIDTH(BRANCH_COUNT);

    // ----------------------------------------------------------
    // Write decode

    // High when the index names an entry that exists
    // With a non power of two count the top index values fall outside
    logic index_valid;

    // Entry currently held in each slot
    branch_cfg_t entry_q [BRANCH_COUNT];

    always_comb begin
        index_valid = (int'(config_index) < BRANCH_COUNT);
    end

    // ----------------------------------------------------------
    // Entry storage

    // Reset clears every entry so all enables come up low
    // A write lands at the edge and shows at the outputs after it
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < BRANCH_COUNT; i++) begin
                entry_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < BRANCH_COUNT; i++) begin
                if (config_write && index_valid &&
                    (config_index == INDEX_WIDTH'(i))) begin
                    entry_q[i] <= config_data;
                end
            end
        end
    end

    // Entries leave the block directly from the registers
    always_comb begin
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            entries[i] = entry_q[i];
        end
    end

endmodule

// ==== hdl/branch_detector.sv ====
// ----------------------------------------------------------
// Branch detector
// Compares one branch entry against the current pc and ALU
// flags and raises that entry's jump and cancel requests
// ----------------------------------------------------------

module branch_detector (
    // Entry under test
    input  branch_pkg::branch_cfg_t entry,

    // Current fetch address and previous result flags
    input  branch_pkg::pc_t         pc,
    input  branch_pkg::alu_flags_t  flags,

    // Requests to the arbiter
    output logic                    jump,
    output logic                    cancel,
    output branch_pkg::pc_t         destination
);

    import branch_pkg::*;

    // The entry is live and sits at the current address
    logic origin_match;

    // The entry's condition holds on the current flags
    logic condition_met;

    // Match and condition together
    logic taken;

    // ----------------------------------------------------------
    // Condition decode

    // Unused encodings behave as never
    always_comb begin
        case (entry.condition)
            COND_NEVER:    condition_met = 1'b0;
            COND_ALWAYS:   condition_met = 1'b1;
            COND_ZERO:     condition_met = flags.zero;
            COND_NONZERO:  condition_met = ~flags.zero;
            COND_NEGATIVE: condition_met = flags.negative;
            COND_POSITIVE: condition_met = ~flags.zero & ~flags.negative;
            default:       condition_met = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // Requests

    always_comb begin
        origin_match = entry.enable && (entry.origin == pc);
        taken        = origin_match && condition_met;
        jump         = taken;
        // A matched entry that went the other way than predicted
        // must cancel the instruction already fetched behind it
        cancel       = origin_match && (taken != entry.predict_taken);
        // Destination only matters once the arbiter grants this entry
        destination  = entry.destination;
    end

endmodule

// ==== hdl/one_hot_mux.sv ====
// ----------------------------------------------------------
// One-hot multiplexer
// AND-OR selector of one word out of many, zero when no
// selector bit is set
// ----------------------------------------------------------

module one_hot_mux #(
    parameter int WORD_WIDTH = 1,
    parameter int WORD_COUNT = 2
) (
    input  logic [WORD_COUNT-1:0]            selectors,
    input  logic [WORD_WIDTH*WORD_COUNT-1:0] words_in,
    output logic [WORD_WIDTH-1:0]            word_out
);

    // Word 0 sits in the lowest bits of words_in
    // Several set selectors would OR their words, callers keep it one-hot
    always_comb begin
        word_out = '0;
        for (int i = 0; i < WORD_COUNT; i++) begin
            word_out = word_out |
                       (words_in[i*WORD_WIDTH +: WORD_WIDTH] & {WORD_WIDTH{selectors[i]}});
        end
    end

endmodule

// ==== hdl/branch_arbiter.sv ====
// ----------------------------------------------------------
// Branch arbiter
// Grants the lowest-index jump request, registers the grant,
// then picks the matching cancel bit and destination
// ----------------------------------------------------------

module branch_arbiter #(
    parameter int BRANCH_COUNT = 4
) (
    input  logic                                       clock,
    input  logic                                       rst,

    // Requests from the detector array
    input  logic [BRANCH_COUNT-1:0]                    cancels,
    input  logic [BRANCH_COUNT-1:0]                    jumps,
    input  logic [branch_pkg::PC_WIDTH*BRANCH_COUNT-1:0] jump_destinations,

    // Selected outcome, one cycle after the requests
    output logic                                       cancel,
    output logic                                       jump,
    output branch_pkg::pc_t                            jump_destination
);

    import branch_pkg::*;

    // The "none" outcome is treated as one more request, at the top
    localparam int BRANCH_COUNT_ALL = BRANCH_COUNT + 1;

    // ----------------------------------------------------------
    // Stage 0

    logic                             jumps_any;
    logic [BRANCH_COUNT_ALL-1:0]      jumps_all;
    logic [BRANCH_COUNT_ALL-1:0]      jumps_granted;

    // Stage 1 registers
    logic [BRANCH_COUNT_ALL-1:0]      jumps_granted_q;
    logic [BRANCH_COUNT_ALL-1:0]      cancels_all_q;
    logic [PC_WIDTH*BRANCH_COUNT-1:0] jump_destinations_q;

    // The "none" bit is set only when no real request is, so the grant
    // always holds exactly one bit
    // Lowest set bit isolated by AND with the two's complement
    always_comb begin
        jumps_any     = |jumps;
        jumps_all     = {~jumps_any, jumps};
        jumps_granted = jumps_all & (~jumps_all + 1'b1);
    end

    // With no jump granted any matched branch may still cancel, so the
    // OR of all cancels stands in for the "none" outcome
    always_ff @(posedge clock) begin
        if (rst) begin
            jump                <= 1'b0;
            jumps_granted_q     <= '0;
            cancels_all_q       <= '0;
            jump_destinations_q <= '0;
        end else begin
            jump                <= jumps_any;
            jumps_granted_q     <= jumps_granted;
            cancels_all_q       <= {|cancels, cancels};
            jump_destinations_q <= jump_destinations;
        end
    end

    // ----------------------------------------------------------
    // Stage 1, combinational from the registers above

    one_hot_mux #(
        .WORD_WIDTH (1),
        .WORD_COUNT (BRANCH_COUNT_ALL)
    ) cancel_selector (
        .selectors  (jumps_granted_q),
        .words_in   (cancels_all_q),
        .word_out   (cancel)
    );

    // Dropping the "none" bit leaves no selector set when nothing was
    // granted, which drives the destination to zero
    one_hot_mux #(
        .WORD_WIDTH (PC_WIDTH),
        .WORD_COUNT (BRANCH_COUNT)
    ) destination_selector (
        .selectors  (jumps_granted_q[BRANCH_COUNT-1:0]),
        .words_in   (jump_destinations_q),
        .word_out   (jump_destination)
    );

endmodule

// ==== hdl/multiway_branch_unit.sv ====
// ----------------------------------------------------------
// Multiway branch unit
// Branch resolution for the fetch stage: entry registers,
// one detector per entry, and the priority arbiter
// ----------------------------------------------------------

module multiway_branch_unit #(
    parameter int BRANCH_COUNT = 4
) (
    input  logic                    clock,
    input  logic                    rst,

    // Software entry writes
    input  logic                    config_write,
    input  logic [branch_pkg::BRANCH_INDEX_WIDTH(BRANCH_COUNT)-1:0] config_index,
    input  branch_pkg::branch_cfg_t config_data,

    // Fetch address and ALU flags of the current cycle
    input  branch_pkg::pc_t         pc,
    input  branch_pkg::alu_flags_t  flags,

    // Resolved branch, one cycle later
    output logic                    jump,
    output logic                    cancel,
    output branch_pkg::pc_t         jump_destination
);

    import branch_pkg::*;

    branch_cfg_t                      entries [BRANCH_COUNT];
    logic [BRANCH_COUNT-1:0]          jumps;
    logic [BRANCH_COUNT-1:0]          cancels;
    logic [PC_WIDTH*BRANCH_COUNT-1:0] destinations;

    branch_config_regs #(
        .BRANCH_COUNT (BRANCH_COUNT)
    ) config_regs (
        .clock        (clock),
        .rst          (rst),
        .config_write (config_write),
        .config_index (config_index),
        .config_data  (config_data),
        .entries      (entries)
    );

    // One detector per entry, each owning one slot of the request vectors
    for (genvar i = 0; i < BRANCH_COUNT; i++) begin : g_detector
        branch_detector detector (
            .entry       (entries[i]),
            .pc          (pc),
            .flags       (flags),
            .jump        (jumps[i]),
            .cancel      (cancels[i]),
            .destination (destinations[i*PC_WIDTH +: PC_WIDTH])
        );
    end

    branch_arbiter #(
        .BRANCH_COUNT      (BRANCH_COUNT)
    ) arbiter (
        .clock             (clock),
        .rst               (rst),
        .cancels           (cancels),
        .jumps             (jumps),
        .jump_destinations (destinations),
        .cancel            (cancel),
        .jump              (jump),
        .jump_destination  (jump_destination)
    );

endmodule

// ==== verif/branch_checker.sv ====
// ----------------------------------------------------------
// Branch checker
// Watches the branch unit ports, mirrors the entry writes,
// predicts the resolved branch and compares one cycle later
// ----------------------------------------------------------

module branch_checker #(
    parameter int BRANCH_COUNT = 4
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    config_write,
    input  logic [branch_pkg::BRANCH_INDEX_WIDTH(BRANCH_COUNT)-1:0] config_index,
    input  branch_pkg::branch_cfg_t config_data,
    input  branch_pkg::pc_t         pc,
    input  branch_pkg::alu_flags_t  flags,
    input  logic                    jump,
    input  logic                    cancel,
    input  branch_pkg::pc_t         jump_destination,
    output int                      error_count,
    output int                      check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import branch_pkg::*;

    // Model copy of the entry registers
    branch_cfg_t model [BRANCH_COUNT];

    // Expected outputs for the cycle after the last rising edge
    logic expected_valid = 1'b0;
    logic expected_jump;
    logic expected_cancel;
    pc_t  expected_destination;

    // Condition table, positive being neither zero nor negative
    function automatic logic condition_holds(input branch_cond_t condition,
                                             input alu_flags_t f);
        case (condition)
            COND_ALWAYS:   return 1'b1;
            COND_ZERO:     return f.zero;
            COND_NONZERO:  return !f.zero;
            COND_NEGATIVE: return f.negative;
            COND_POSITIVE: return !f.zero && !f.negative;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [PC_WIDTH-1:0] expected,
                                 input logic [PC_WIDTH-1:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // ----------------------------------------------------------
    // Prediction at the rising edge, from the entries as they
    // stood before any write on that same edge
    always @(posedge clock) begin : predict
        logic matched;
        logic taken;
        logic mispredicted;
        logic granted;
        logic cancel_any;
        granted    = 1'b0;
        cancel_any = 1'b0;
        expected_cancel      = 1'b0;
        expected_destination = '0;
        if (rst) begin
            for (int i = 0; i < BRANCH_COUNT; i++) begin
                model[i] = '0;
            end
        end else begin
            for (int i = 0; i < BRANCH_COUNT; i++) begin
                matched      = model[i].enable && (model[i].origin == pc);
                taken        = matched && condition_holds(model[i].condition, flags);
                mispredicted = matched && (taken != model[i].predict_taken);
                cancel_any   = cancel_any | mispredicted;
                // Lowest index among the taken entries wins
                if (taken && !granted) begin
                    granted              = 1'b1;
                    expected_cancel      = mispredicted;
                    expected_destination = model[i].destination;
                end
            end
            // Nothing granted, so any mispredicted match cancels
            if (!granted) begin
                expected_cancel = cancel_any;
            end
            if (config_write && (int'(config_index) < BRANCH_COUNT)) begin
                model[config_index] = config_data;
            end
        end
        expected_jump  = granted;
        expected_valid = 1'b1;
    end

    // Outputs are registered, so mid-cycle they are settled
    always @(negedge clock) begin
        if (expected_valid) begin
            compare_value("jump", expected_jump, jump);
            compare_value("cancel", expected_cancel, cancel);
            compare_value("jump_destination", expected_destination, jump_destination);
        end
    end

endmodule

// ==== verif/multiway_branch_unit_tb.sv ====
// ----------------------------------------------------------
// Multiway branch unit testbench
// Clock, reset, random entry writes with pc and flag stimulus,
// and a cycle limit on the whole run
// ----------------------------------------------------------

module multiway_branch_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import branch_pkg::*;

    localparam int BRANCH_COUNT  = 4;
    localparam int INDEX_WIDTH   = BRANCH_INDEX_WIDTH(BRANCH_COUNT);
    localparam int RESET_CYCLES  = 5;
    localparam int SETTLE_CYCLES = 2;

    // Test lengths, in cycles per round
    localparam int TEST1_CYCLES = 20;
    localparam int TEST2_ROUNDS = 2;
    localparam int TEST2_CYCLES = 20;
    localparam int TEST3_ROUNDS = 40;
    localparam int TEST3_CYCLES = 2;
    localparam int TEST4_ROUNDS = 6;
    localparam int TEST4_CYCLES = 8;
    localparam int TEST5_ROUNDS = 6;
    localparam int TEST5_CYCLES = 6;
    localparam int TEST6_CYCLES = 300;

    localparam int TOTAL_CYCLES = RESET_CYCLES + TEST1_CYCLES
        + TEST2_ROUNDS * (1 + TEST2_CYCLES) + TEST3_ROUNDS * (1 + TEST3_CYCLES)
        + TEST4_ROUNDS * (BRANCH_COUNT + TEST4_CYCLES)
        + TEST5_ROUNDS * (BRANCH_COUNT + TEST5_CYCLES) + TEST6_CYCLES + 6 * SETTLE_CYCLES;
    localparam int CYCLE_LIMIT = TOTAL_CYCLES + 50;

    logic                   clock = 1'b0;
    logic                   rst;
    logic                   config_write;
    logic [INDEX_WIDTH-1:0] config_index;
    branch_cfg_t            config_data;
    pc_t                    pc;
    alu_flags_t             flags;
    logic                   jump;
    logic                   cancel;
    pc_t                    jump_destination;

    int          seed;
    int          cycle_count = 0;
    int          error_count;
    int          check_count;
    int          errors_before = 0;
    pc_t         origin;
    pc_t         origin_pool [4];
    branch_cond_t condition;

    always #10 clock = ~clock;

    multiway_branch_unit #(.BRANCH_COUNT(BRANCH_COUNT)) uut (
        .clock (clock), .rst (rst),
        .config_write (config_write), .config_index (config_index),
        .config_data (config_data), .pc (pc), .flags (flags),
        .jump (jump), .cancel (cancel), .jump_destination (jump_destination)
    );

    branch_checker #(.BRANCH_COUNT(BRANCH_COUNT)) result_checker (
        .clock (clock), .rst (rst),
        .config_write (config_write), .config_index (config_index),
        .config_data (config_data), .pc (pc), .flags (flags),
        .jump (jump), .cancel (cancel), .jump_destination (jump_destination),
        .error_count (error_count), .check_count (check_count)
    );

    // ----------------------------------------------------------
    // Cycle limit, a stuck run ends here
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic pc_t random_pc();
        return pc_t'($random(seed));
    endfunction

    function automatic alu_flags_t random_flags();
        return alu_flags_t'(2'($random(seed)));
    endfunction

    function automatic branch_cond_t random_cond();
        return branch_cond_t'(3'({$random(seed)} % 6));
    endfunction

    // Destination and predicted direction are always random
    function automatic branch_cfg_t make_entry(input pc_t entry_origin,
                                               input branch_cond_t entry_cond,
                                               input logic entry_enable);
        branch_cfg_t entry;
        entry.origin        = entry_origin;
        entry.destination   = random_pc();
        entry.condition     = entry_cond;
        entry.predict_taken = 1'($random(seed));
        entry.enable        = entry_enable;
        return entry;
    endfunction

    // One cycle of stimulus, applied on the falling edge
    task automatic step(input logic write, input int index, input branch_cfg_t data,
                        input pc_t next_pc, input alu_flags_t next_flags);
        @(negedge clock);
        config_write = write;
        config_index = INDEX_WIDTH'(index);
        config_data  = data;
        pc           = next_pc;
        flags        = next_flags;
    endtask

    // Lets the last stimulus of a test reach its comparison
    // Ends on a rising edge, clear of the falling-edge comparisons
    task automatic settle();
        repeat (SETTLE_CYCLES) step(1'b0, 0, '0, pc, flags);
        @(posedge clock);
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished, %0d failed checks", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        seed         = 19933;
        rst          = 1'b1;
        config_write = 1'b0;
        config_index = '0;
        config_data  = '0;
        pc           = '0;
        flags        = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;

        // All entries disabled, nothing may jump
        for (int i = 0; i < TEST1_CYCLES; i++) step(1'b0, 0, '0, random_pc(), random_flags());
        settle();
        report_test("reset_state");

        // Unconditional entry, pc hits its origin about half the time
        for (int r = 0; r < TEST2_ROUNDS; r++) begin
            origin = random_pc();
            step(1'b1, 0, make_entry(origin, COND_ALWAYS, 1'b1), random_pc(), random_flags());
            for (int i = 0; i < TEST2_CYCLES; i++) begin
                step(1'b0, 0, '0, ({$random(seed)} % 2) ? origin : random_pc(), random_flags());
            end
        end
        settle();
        report_test("single_branch");

        origin = random_pc();
        for (int r = 0; r < TEST3_ROUNDS; r++) begin
            step(1'b1, 0, make_entry(origin, random_cond(), 1'b1), origin, random_flags());
            for (int i = 0; i < TEST3_CYCLES; i++) step(1'b0, 0, '0, origin, random_flags());
        end
        settle();
        report_test("conditions");

        // Every entry on one origin with mixed conditions
        for (int r = 0; r < TEST4_ROUNDS; r++) begin
            origin = random_pc();
            for (int e = 0; e < BRANCH_COUNT; e++) begin
                step(1'b1, e, make_entry(origin, random_cond(), 1'b1), random_pc(), random_flags());
            end
            for (int i = 0; i < TEST4_CYCLES; i++) step(1'b0, 0, '0, origin, random_flags());
        end
        settle();
        report_test("priority");

        // With both flags clear none of never, zero and negative holds
        for (int r = 0; r < TEST5_ROUNDS; r++) begin
            origin = random_pc();
            for (int e = 0; e < BRANCH_COUNT; e++) begin
                case ({$random(seed)} % 3)
                    0:       condition = COND_NEVER;
                    1:       condition = COND_ZERO;
                    default: condition = COND_NEGATIVE;
                endcase
                step(1'b1, e, make_entry(origin, condition, ({$random(seed)} % 4) != 0),
                     random_pc(), random_flags());
            end
            for (int i = 0; i < TEST5_CYCLES; i++) step(1'b0, 0, '0, origin, '0);
        end
        settle();
        report_test("no_jump_taken");

        // Writes on about a quarter of the cycles, pc mostly from the pool
        for (int p = 0; p < 4; p++) origin_pool[p] = random_pc();
        for (int i = 0; i < TEST6_CYCLES; i++) begin
            step(({$random(seed)} % 4) == 0, {$random(seed)} % BRANCH_COUNT,
                 make_entry(origin_pool[{$random(seed)} % 4], random_cond(),
                            ({$random(seed)} % 5) != 0),
                 (({$random(seed)} % 4) != 0) ? origin_pool[{$random(seed)} % 4] : random_pc(),
                 random_flags());
        end
        settle();
        report_test("random_run");

        $display("Checks run: %0d, checks failed: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== multiway_branch_unit.f ====
hdl/branch_pkg.sv
hdl/branch_config_regs.sv
hdl/branch_detector.sv
hdl/one_hot_mux.sv
hdl/branch_arbiter.sv
hdl/multiway_branch_unit.sv
verif/branch_checker.sv
verif/multiway_branch_unit_tb.sv
